/* hw/bus_pkg.sv */
package bus_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;
  localparam int STRB_W     = AXI_DATA_W / 8;

  // AXI xRESP codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // same encoding as AxSIZE
  typedef enum logic [2:0] {
    SZ_BYTE = 3'b000,
    SZ_HALF = 3'b001,
    SZ_WORD = 3'b010
  } xfer_size_e;

  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage

/* hw/arb_pkg.sv */
package arb_pkg;

  typedef enum logic [1:0] {
    OP_FETCH = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2
  } bus_op_e;

  typedef enum logic [2:0] {
    S_IDLE  = 3'd0,
    S_AR    = 3'd1,
    S_R     = 3'd2,
    S_AW_W  = 3'd3,
    S_B     = 3'd4,
    S_TIMER = 3'd5
  } seq_state_e;

  typedef enum logic {
    A_IDLE = 1'b0,
    A_BUSY = 1'b1
  } arb_state_e;

  // mtime words relative to the CLINT base
  localparam logic [31:0] MTIME_LO_OFS = 32'h0000_0000;
  localparam logic [31:0] MTIME_HI_OFS = 32'h0000_0004;

endpackage

/* hw/client_arbiter.sv */
`timescale 1ns/1ps

module client_arbiter
  import bus_pkg::*;
  import arb_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              ifu_req_i,
  input  logic [ADDR_W-1:0] ifu_addr_i,
  input  logic              lsu_req_i,
  input  logic              lsu_we_i,
  input  logic [ADDR_W-1:0] lsu_addr_i,
  input  xfer_size_e        lsu_size_i,
  input  logic [DATA_W-1:0] lsu_wdata_i,
  input  logic              release_i,
  output logic              cmd_start_o,
  output bus_op_e           cmd_op_o,
  output logic [ADDR_W-1:0] cmd_addr_o,
  output xfer_size_e        cmd_size_o,
  output logic [DATA_W-1:0] cmd_wdata_o
);

  arb_state_e state_q;
  logic       any_req;
  logic       grant;

  assign any_req = ifu_req_i | lsu_req_i;
  assign grant   = (state_q == A_IDLE) && any_req;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= A_IDLE;
      cmd_start_o <= 1'b0;
    end
    else
    begin
      cmd_start_o <= grant;
      case (state_q)
        A_IDLE:
        begin
          if (any_req)
            state_q <= A_BUSY;
        end
        A_BUSY:
        begin
          if (release_i)  // ack of the last client fell
            state_q <= A_IDLE;
        end
      endcase
    end
  end

  // lsu wins a tie
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      if (lsu_req_i)
      begin
        if (lsu_we_i)
          cmd_op_o <= OP_STORE;
        else
          cmd_op_o <= OP_LOAD;
        cmd_addr_o  <= lsu_addr_i;
        cmd_size_o  <= lsu_size_i;
        cmd_wdata_o <= lsu_wdata_i;
      end
      else
      begin
        cmd_op_o    <= OP_FETCH;
        cmd_addr_o  <= ifu_addr_i;
        cmd_size_o  <= SZ_WORD;  // fetches are always whole words
        cmd_wdata_o <= '0;
      end
    end
  end

  // no second command until the router hands the bus back
  assert property (@(posedge clk) disable iff (rst)
    cmd_start_o |=> (!cmd_start_o throughout release_i[->1]))
    else $error("cmd_start while a transaction is outstanding");

endmodule

/* hw/axi_master_seq.sv */
`timescale 1ns/1ps

module axi_master_seq
  import bus_pkg::*;
  import arb_pkg::*;
#(
  parameter logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_bff8,
  parameter logic [3:0]        AXI_ID     = 4'h0
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmd_start_i,
  input  bus_op_e               cmd_op_i,
  input  logic [ADDR_W-1:0]     cmd_addr_i,
  input  xfer_size_e            cmd_size_i,
  input  logic [DATA_W-1:0]     cmd_wdata_i,
  output logic [3:0]            m_arid_o,
  output logic [ADDR_W-1:0]     m_araddr_o,
  output logic [7:0]            m_arlen_o,
  output logic [2:0]            m_arsize_o,
  output logic [1:0]            m_arburst_o,
  output logic                  m_arvalid_o,
  input  logic                  m_arready_i,
  input  logic [AXI_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]            m_rresp_i,
  input  logic                  m_rlast_i,
  input  logic                  m_rvalid_i,
  output logic                  m_rready_o,
  output logic [3:0]            m_awid_o,
  output logic [ADDR_W-1:0]     m_awaddr_o,
  output logic [7:0]            m_awlen_o,
  output logic [2:0]            m_awsize_o,
  output logic [1:0]            m_awburst_o,
  output logic                  m_awvalid_o,
  input  logic                  m_awready_i,
  output logic [AXI_DATA_W-1:0] m_wdata_o,
  output logic [STRB_W-1:0]     m_wstrb_o,
  output logic                  m_wlast_o,
  output logic                  m_wvalid_o,
  input  logic                  m_wready_i,
  input  logic [1:0]            m_bresp_i,
  input  logic                  m_bvalid_i,
  output logic                  m_bready_o,
  output logic                  timer_rd_o,
  output logic                  timer_hi_o,
  input  logic [DATA_W-1:0]     timer_rdata_i,
  output logic                  seq_done_o,
  output bus_op_e               seq_op_o,
  output logic [DATA_W-1:0]     seq_rdata_o
);

  seq_state_e        state_q;
  logic              aw_done_q;
  logic              w_done_q;
  logic              aw_ok;
  logic              w_ok;
  logic [ADDR_W-1:0] clint_ofs;
  logic [ADDR_W-1:0] word_ofs;
  logic              is_timer;
  logic [STRB_W-1:0] size_strb;
  logic [DATA_W-1:0] wword;

  // mtime decode, loads only
  assign clint_ofs  = cmd_addr_i - CLINT_BASE;
  assign word_ofs   = {clint_ofs[ADDR_W-1:2], 2'b00};
  assign is_timer   = (cmd_op_i == OP_LOAD) &&
                      ((word_ofs == MTIME_LO_OFS) || (word_ofs == MTIME_HI_OFS));
  assign timer_rd_o = cmd_start_i && (state_q == S_IDLE) && is_timer;
  assign timer_hi_o = (word_ofs == MTIME_HI_OFS);

  assign m_arid_o    = AXI_ID;
  assign m_araddr_o  = cmd_addr_i;
  assign m_arlen_o   = 8'd0;
  assign m_arsize_o  = cmd_size_i;
  assign m_arburst_o = AXI_BURST_INCR;
  assign m_arvalid_o = (state_q == S_AR);
  assign m_rready_o  = (state_q == S_R);

  assign m_awid_o    = AXI_ID;
  assign m_awaddr_o  = cmd_addr_i;
  assign m_awlen_o   = 8'd0;
  assign m_awsize_o  = cmd_size_i;
  assign m_awburst_o = AXI_BURST_INCR;
  assign m_awvalid_o = (state_q == S_AW_W) && !aw_done_q;
  assign m_wvalid_o  = (state_q == S_AW_W) && !w_done_q;
  assign m_wlast_o   = m_wvalid_o;  // single beat
  assign m_bready_o  = (state_q == S_B);

  always_comb
  begin
    case (cmd_size_i)
      SZ_BYTE: size_strb = STRB_W'('h01);
      SZ_HALF: size_strb = STRB_W'('h03);
      default: size_strb = STRB_W'('h0f);
    endcase
  end

  assign m_wstrb_o = size_strb << cmd_addr_i[2:0];
  assign wword     = cmd_wdata_i << {cmd_addr_i[1:0], 3'b000};
  assign m_wdata_o = {wword, wword};  // strobes pick the half

  assign aw_ok = aw_done_q | m_awready_i;
  assign w_ok  = w_done_q | m_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q    <= S_IDLE;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
      seq_done_o <= 1'b0;
    end
    else
    begin
      seq_done_o <= 1'b0;
      case (state_q)
        S_IDLE:
        begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (cmd_start_i)
          begin
            if (is_timer)
              state_q <= S_TIMER;
            else if (cmd_op_i == OP_STORE)
              state_q <= S_AW_W;
            else
              state_q <= S_AR;
          end
        end
        S_AR:
        begin
          if (m_arready_i)
            state_q <= S_R;
        end
        S_R:
        begin
          if (m_rvalid_i)
          begin
            state_q    <= S_IDLE;
            seq_done_o <= 1'b1;
          end
        end
        S_AW_W:
        begin
          aw_done_q <= aw_ok;
          w_done_q  <= w_ok;
          if (aw_ok && w_ok)
            state_q <= S_B;
        end
        S_B:
        begin
          if (m_bvalid_i)
          begin
            state_q    <= S_IDLE;
            seq_done_o <= 1'b1;
          end
        end
        S_TIMER:
        begin
          state_q    <= S_IDLE;  // timer word is valid this cycle
          seq_done_o <= 1'b1;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_start_i)
      seq_op_o <= cmd_op_i;
    if ((state_q == S_R) && m_rvalid_i)
      seq_rdata_o <= cmd_addr_i[2] ? m_rdata_i[AXI_DATA_W-1:DATA_W] : m_rdata_i[DATA_W-1:0];
    else if (state_q == S_TIMER)
      seq_rdata_o <= timer_rdata_i;
  end

  assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> (m_rresp_i == OKAY) && m_rlast_i)
    else $error("read response not OKAY or not last");

  assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> (m_bresp_i == OKAY))
    else $error("write response not OKAY");

  // address channels hold until accepted
  assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o))
    else $error("AR dropped or changed before arready");

  assert property (@(posedge clk) disable iff (rst)
    m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o))
    else $error("AW dropped or changed before awready");

endmodule

/* hw/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer
  import bus_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rd_i,
  input  logic              hi_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [2*DATA_W-1:0] mtime_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= '0;
    else
      mtime_q <= mtime_q + 1'b1;
  end

  // word picked at the read strobe
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (hi_i)
        rdata_o <= mtime_q[2*DATA_W-1:DATA_W];
      else
        rdata_o <= mtime_q[DATA_W-1:0];
    end
  end

endmodule

/* hw/resp_router.sv */
`timescale 1ns/1ps

module resp_router
  import bus_pkg::*;
  import arb_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              seq_done_i,
  input  bus_op_e           seq_op_i,
  input  logic [DATA_W-1:0] seq_rdata_i,
  input  logic              ifu_req_i,
  input  logic              lsu_req_i,
  output logic              ifu_ack_o,
  output logic [DATA_W-1:0] ifu_rdata_o,
  output logic              lsu_ack_o,
  output logic [DATA_W-1:0] lsu_rdata_o,
  output logic              release_o
);

  logic to_ifu;

  assign to_ifu = (seq_op_i == OP_FETCH);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ifu_ack_o <= 1'b0;
      lsu_ack_o <= 1'b0;
      release_o <= 1'b0;
    end
    else
    begin
      release_o <= 1'b0;
      if (seq_done_i)
      begin
        if (to_ifu)
          ifu_ack_o <= 1'b1;
        else
          lsu_ack_o <= 1'b1;
      end
      // req gone, close the handshake
      if (ifu_ack_o && !ifu_req_i)
      begin
        ifu_ack_o <= 1'b0;
        release_o <= 1'b1;
      end
      if (lsu_ack_o && !lsu_req_i)
      begin
        lsu_ack_o <= 1'b0;
        release_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (seq_done_i && to_ifu)
      ifu_rdata_o <= seq_rdata_i;
    if (seq_done_i && (seq_op_i == OP_LOAD))  // stores leave lsu data alone
      lsu_rdata_o <= seq_rdata_i;
  end

  // an ack only stays up while its req is held
  assert property (@(posedge clk) disable iff (rst)
    !ifu_req_i |=> !ifu_ack_o)
    else $error("ifu_ack high without ifu_req");

  assert property (@(posedge clk) disable iff (rst)
    !lsu_req_i |=> !lsu_ack_o)
    else $error("lsu_ack high without lsu_req");

endmodule

/* hw/mem_bus_top.sv */
`timescale 1ns/1ps

module mem_bus_top
  import bus_pkg::*;
  import arb_pkg::*;
#(
  parameter logic [ADDR_W-1:0] CLINT_BASE = 32'h0200_bff8,
  parameter logic [3:0]        AXI_ID     = 4'h0
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ifu_req_i,
  input  logic [ADDR_W-1:0]     ifu_addr_i,
  output logic                  ifu_ack_o,
  output logic [DATA_W-1:0]     ifu_rdata_o,
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  logic [ADDR_W-1:0]     lsu_addr_i,
  input  xfer_size_e            lsu_size_i,
  input  logic [DATA_W-1:0]     lsu_wdata_i,
  output logic                  lsu_ack_o,
  output logic [DATA_W-1:0]     lsu_rdata_o,
  output logic [3:0]            m_arid_o,
  output logic [ADDR_W-1:0]     m_araddr_o,
  output logic [7:0]            m_arlen_o,
  output logic [2:0]            m_arsize_o,
  output logic [1:0]            m_arburst_o,
  output logic                  m_arvalid_o,
  input  logic                  m_arready_i,
  input  logic [AXI_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]            m_rresp_i,
  input  logic                  m_rlast_i,
  input  logic                  m_rvalid_i,
  output logic                  m_rready_o,
  output logic [3:0]            m_awid_o,
  output logic [ADDR_W-1:0]     m_awaddr_o,
  output logic [7:0]            m_awlen_o,
  output logic [2:0]            m_awsize_o,
  output logic [1:0]            m_awburst_o,
  output logic                  m_awvalid_o,
  input  logic                  m_awready_i,
  output logic [AXI_DATA_W-1:0] m_wdata_o,
  output logic [STRB_W-1:0]     m_wstrb_o,
  output logic                  m_wlast_o,
  output logic                  m_wvalid_o,
  input  logic                  m_wready_i,
  input  logic [1:0]            m_bresp_i,
  input  logic                  m_bvalid_i,
  output logic                  m_bready_o
);

  logic              cmd_start;
  bus_op_e           cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  xfer_size_e        cmd_size;
  logic [DATA_W-1:0] cmd_wdata;
  logic              seq_done;
  bus_op_e           seq_op;
  logic [DATA_W-1:0] seq_rdata;
  logic              timer_rd;
  logic              timer_hi;
  logic [DATA_W-1:0] timer_rdata;
  logic              bus_release;  // ack fell, arbiter may grant again

  // client and AXI ports share names with the top ports
  client_arbiter u_arb (
    .release_i   (bus_release),
    .cmd_start_o (cmd_start),
    .cmd_op_o    (cmd_op),
    .cmd_addr_o  (cmd_addr),
    .cmd_size_o  (cmd_size),
    .cmd_wdata_o (cmd_wdata),
    .*
  );

  axi_master_seq #(
    .CLINT_BASE (CLINT_BASE),
    .AXI_ID     (AXI_ID)
  ) u_seq (
    .cmd_start_i   (cmd_start),
    .cmd_op_i      (cmd_op),
    .cmd_addr_i    (cmd_addr),
    .cmd_size_i    (cmd_size),
    .cmd_wdata_i   (cmd_wdata),
    .timer_rd_o    (timer_rd),
    .timer_hi_o    (timer_hi),
    .timer_rdata_i (timer_rdata),
    .seq_done_o    (seq_done),
    .seq_op_o      (seq_op),
    .seq_rdata_o   (seq_rdata),
    .*
  );

  clint_timer u_timer (
    .clk     (clk),
    .rst     (rst),
    .rd_i    (timer_rd),
    .hi_i    (timer_hi),
    .rdata_o (timer_rdata)
  );

  resp_router u_router (
    .seq_done_i  (seq_done),
    .seq_op_i    (seq_op),
    .seq_rdata_i (seq_rdata),
    .release_o   (bus_release),
    .*
  );

endmodule

/* dv/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
  import bus_pkg::*;
#(
  parameter int WORDS = 1024
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ADDR_W-1:0]     araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic [AXI_DATA_W-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rlast_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  logic [ADDR_W-1:0]     awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [AXI_DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0]     wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i
);

  localparam int IDX_W = $clog2(WORDS);

  logic [AXI_DATA_W-1:0] mem [0:WORDS-1];
  logic [IDX_W-1:0]      rd_idx;
  logic [IDX_W-1:0]      wr_idx;
  logic [AXI_DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0]     wstrb_q;
  logic                  rd_pend;
  logic                  aw_got;
  logic                  w_got;
  logic                  b_pend;
  logic [1:0]            ar_wait;
  logic [1:0]            r_wait;
  logic [1:0]            aw_wait;
  logic [1:0]            w_wait;
  logic [1:0]            b_wait;

  // every byte gets a value folded from its full address
  function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
    logic [7:0] folded;
    folded = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
    return folded * 8'd37 + 8'h5b;
  endfunction

  initial
  begin
    logic [AXI_DATA_W-1:0] word;
    for (int i = 0; i < WORDS; i++)
    begin
      for (int b = 0; b < STRB_W; b++)
        word[8*b +: 8] = fill_byte(ADDR_W'(i * STRB_W + b));
      mem[i] <= word;
    end
    arready_o <= 1'b0;
    rvalid_o  <= 1'b0;
    rdata_o   <= '0;
    awready_o <= 1'b0;
    wready_o  <= 1'b0;
    bvalid_o  <= 1'b0;
  end

  assign rresp_o = OKAY;
  assign rlast_o = 1'b1;  // single beats only
  assign bresp_o = OKAY;

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_pend   <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
      ar_wait   <= 2'($urandom);
      r_wait    <= 2'($urandom);
      aw_wait   <= 2'($urandom);
      w_wait    <= 2'($urandom);
      b_wait    <= 2'($urandom);
    end
    else
    begin
      if (arready_o && arvalid_i)
      begin
        arready_o <= 1'b0;
        rd_idx    <= araddr_i[3 +: IDX_W];
        rd_pend   <= 1'b1;
        ar_wait   <= 2'($urandom);
      end
      else if (arvalid_i && !arready_o && !rd_pend)
      begin
        if (ar_wait == 2'd0)
          arready_o <= 1'b1;
        else
          ar_wait <= ar_wait - 2'd1;
      end

      if (rvalid_o && rready_i)
      begin
        rvalid_o <= 1'b0;
        rd_pend  <= 1'b0;
        r_wait   <= 2'($urandom);
      end
      else if (rd_pend && !rvalid_o)
      begin
        if (r_wait == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[rd_idx];
        end
        else
          r_wait <= r_wait - 2'd1;
      end

      // aw and w accepted independently
      if (awready_o && awvalid_i)
      begin
        awready_o <= 1'b0;
        wr_idx    <= awaddr_i[3 +: IDX_W];
        aw_got    <= 1'b1;
        aw_wait   <= 2'($urandom);
      end
      else if (awvalid_i && !awready_o && !aw_got)
      begin
        if (aw_wait == 2'd0)
          awready_o <= 1'b1;
        else
          aw_wait <= aw_wait - 2'd1;
      end

      if (wready_o && wvalid_i)
      begin
        wready_o <= 1'b0;
        wdata_q  <= wdata_i;
        wstrb_q  <= wstrb_i;
        w_got    <= 1'b1;
        w_wait   <= 2'($urandom);
      end
      else if (wvalid_i && !wready_o && !w_got)
      begin
        if (w_wait == 2'd0)
          wready_o <= 1'b1;
        else
          w_wait <= w_wait - 2'd1;
      end

      if (aw_got && w_got && !b_pend)
      begin
        for (int b = 0; b < STRB_W; b++)
          if (wstrb_q[b])
            mem[wr_idx][8*b +: 8] <= wdata_q[8*b +: 8];
        b_pend <= 1'b1;
      end

      if (bvalid_o && bready_i)
      begin
        bvalid_o <= 1'b0;
        b_pend   <= 1'b0;
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
        b_wait   <= 2'($urandom);
      end
      else if (b_pend && !bvalid_o)
      begin
        if (b_wait == 2'd0)
          bvalid_o <= 1'b1;
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

endmodule

/* dv/mem_bus_tb.sv */
`timescale 1ns/1ps

module mem_bus_tb
  import bus_pkg::*;
  import arb_pkg::*;
();

  localparam logic [31:0]       SEED           = 32'h1aff;
  localparam logic [ADDR_W-1:0] CLINT_BASE     = 32'h0200_bff8;
  localparam logic [3:0]        AXI_ID         = 4'h3;
  localparam int                MEM_BYTES      = 8192;
  localparam int                MIXED_OPS      = 40;
  localparam int                TXN_COUNT      = 80;  // all tests, rounded up
  localparam int                TXN_CYCLES     = 24;  // worst case with 3-cycle delays
  localparam int                TIMEOUT_CYCLES = TXN_COUNT * TXN_CYCLES + 50;

  logic                  clk;
  logic                  rst;
  logic                  ifu_req;
  logic [ADDR_W-1:0]     ifu_addr;
  logic                  ifu_ack;
  logic [DATA_W-1:0]     ifu_rdata;
  logic                  lsu_req;
  logic                  lsu_we;
  logic [ADDR_W-1:0]     lsu_addr;
  xfer_size_e            lsu_size;
  logic [DATA_W-1:0]     lsu_wdata;
  logic                  lsu_ack;
  logic [DATA_W-1:0]     lsu_rdata;
  logic [3:0]            arid;
  logic [ADDR_W-1:0]     araddr;
  logic [7:0]            arlen;
  logic [2:0]            arsize;
  logic [1:0]            arburst;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rlast;
  logic                  rvalid;
  logic                  rready;
  logic [3:0]            awid;
  logic [ADDR_W-1:0]     awaddr;
  logic [7:0]            awlen;
  logic [2:0]            awsize;
  logic [1:0]            awburst;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic [STRB_W-1:0]     wstrb;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;

  logic [7:0] ref_mem [0:MEM_BYTES-1];
  int         err_count;
  int         check_count;
  int         tests_run;
  int         tests_failed;
  int         cycle_cnt;
  logic       watch_ar;
  logic       ar_seen;
  xfer_size_e exp_size;

  mem_bus_top #(
    .CLINT_BASE (CLINT_BASE),
    .AXI_ID     (AXI_ID)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .ifu_req_i   (ifu_req),
    .ifu_addr_i  (ifu_addr),
    .ifu_ack_o   (ifu_ack),
    .ifu_rdata_o (ifu_rdata),
    .lsu_req_i   (lsu_req),
    .lsu_we_i    (lsu_we),
    .lsu_addr_i  (lsu_addr),
    .lsu_size_i  (lsu_size),
    .lsu_wdata_i (lsu_wdata),
    .lsu_ack_o   (lsu_ack),
    .lsu_rdata_o (lsu_rdata),
    .m_arid_o    (arid),
    .m_araddr_o  (araddr),
    .m_arlen_o   (arlen),
    .m_arsize_o  (arsize),
    .m_arburst_o (arburst),
    .m_arvalid_o (arvalid),
    .m_arready_i (arready),
    .m_rdata_i   (rdata),
    .m_rresp_i   (rresp),
    .m_rlast_i   (rlast),
    .m_rvalid_i  (rvalid),
    .m_rready_o  (rready),
    .m_awid_o    (awid),
    .m_awaddr_o  (awaddr),
    .m_awlen_o   (awlen),
    .m_awsize_o  (awsize),
    .m_awburst_o (awburst),
    .m_awvalid_o (awvalid),
    .m_awready_i (awready),
    .m_wdata_o   (wdata),
    .m_wstrb_o   (wstrb),
    .m_wlast_o   (wlast),
    .m_wvalid_o  (wvalid),
    .m_wready_i  (wready),
    .m_bresp_i   (bresp),
    .m_bvalid_i  (bvalid),
    .m_bready_o  (bready)
  );

  axi_mem_model #(.WORDS(MEM_BYTES / 8)) slave (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .rlast_o   (rlast),
    .rvalid_o  (rvalid),
    .rready_i  (rready),
    .awaddr_i  (awaddr),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .wdata_i   (wdata),
    .wstrb_i   (wstrb),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .bresp_o   (bresp),
    .bvalid_o  (bvalid),
    .bready_i  (bready)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (watch_ar && arvalid)
      ar_seen <= 1'b1;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, a transfer never completed", cycle_cnt);
    $display("TEST FAILED");
    $finish;
  end

  // same preload rule as the slave memory
  function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
    logic [7:0] folded;
    folded = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
    return folded * 8'd37 + 8'h5b;
  endfunction

  function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] base;
    base = a & ~32'h3;
    return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
  endfunction

  // strobe = size pattern << addr[2:0], lanes carry the word shifted by addr[1:0]
  function automatic void ref_store(input logic [ADDR_W-1:0] a, input xfer_size_e size,
                                    input logic [DATA_W-1:0] w);
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] lane;
    logic [ADDR_W-1:0] base;
    case (size)
      SZ_BYTE: strb = 8'h01;
      SZ_HALF: strb = 8'h03;
      default: strb = 8'h0f;
    endcase
    strb = strb << a[2:0];
    lane = w << (8 * a[1:0]);
    base = a & ~32'h7;
    for (int j = 0; j < STRB_W; j++)
      if (strb[j])
        ref_mem[base + j] = lane[8*(j%4) +: 8];
  endfunction

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_field(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input xfer_size_e got,
                            input xfer_size_e exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // single-beat INCR with the configured id on every address beat
  always @(posedge clk)
  begin
    if (rst === 1'b0)
    begin
      if (arvalid)
      begin
        check_field("m_arid_o", 8'(arid), 8'(AXI_ID));
        check_field("m_arlen_o", arlen, 8'h00);
        check_field("m_arburst_o", 8'(arburst), 8'(AXI_BURST_INCR));
        check_size("m_arsize_o", xfer_size_e'(arsize), exp_size);
      end
      if (awvalid)
      begin
        check_field("m_awid_o", 8'(awid), 8'(AXI_ID));
        check_field("m_awlen_o", awlen, 8'h00);
        check_field("m_awburst_o", 8'(awburst), 8'(AXI_BURST_INCR));
        check_size("m_awsize_o", xfer_size_e'(awsize), exp_size);
      end
      if (wvalid)
        check_bit("m_wlast_o", wlast, 1'b1);
    end
  end

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before)
      $display("%s: passed", name);
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic lsu_transfer(input logic we, input logic [ADDR_W-1:0] addr,
                              input xfer_size_e size, input logic [DATA_W-1:0] wd,
                              output logic [DATA_W-1:0] rd, output time ack_time);
    exp_size = size;
    @(posedge clk);
    lsu_req   <= 1'b1;
    lsu_we    <= we;
    lsu_addr  <= addr;
    lsu_size  <= size;
    lsu_wdata <= wd;
    do
      @(posedge clk);
    while (!lsu_ack);
    ack_time = $time;
    rd       = lsu_rdata;
    lsu_req <= 1'b0;
    while (lsu_ack)  // four-phase, wait for ack to drop
      @(posedge clk);
  endtask

  task automatic ifu_fetch(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rd,
                           output time ack_time);
    exp_size = SZ_WORD;
    @(posedge clk);
    ifu_req  <= 1'b1;
    ifu_addr <= addr;
    do
      @(posedge clk);
    while (!ifu_ack);
    ack_time = $time;
    rd       = ifu_rdata;
    ifu_req <= 1'b0;
    while (ifu_ack)
      @(posedge clk);
  endtask

  task automatic store_and_track(input logic [ADDR_W-1:0] addr, input xfer_size_e size,
                                 input logic [DATA_W-1:0] wd);
    logic [DATA_W-1:0] rd;
    time               t;
    lsu_transfer(1'b1, addr, size, wd, rd, t);
    ref_store(addr, size, wd);
  endtask

  task automatic load_and_compare(input logic [ADDR_W-1:0] addr, input xfer_size_e size);
    logic [DATA_W-1:0] rd;
    time               t;
    lsu_transfer(1'b0, addr, size, '0, rd, t);
    check_word("lsu_rdata_o", rd, ref_word(addr));
  endtask

  task automatic test_reset_levels();
    int errs;
    errs = err_count;
    check_bit("m_arvalid_o", arvalid, 1'b0);
    check_bit("m_awvalid_o", awvalid, 1'b0);
    check_bit("m_wvalid_o", wvalid, 1'b0);
    check_bit("ifu_ack_o", ifu_ack, 1'b0);
    check_bit("lsu_ack_o", lsu_ack, 1'b0);
    check_bit("m_rready_o", rready, 1'b0);
    check_bit("m_bready_o", bready, 1'b0);
    report_test("reset_levels", errs);
  endtask

  task automatic test_fetch_halves();
    int                errs;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] rd;
    time               t;
    errs = err_count;
    for (int i = 0; i < 6; i++)
    begin
      addr = ADDR_W'(32'h100 + 12 * i);  // bit 2 alternates
      ifu_fetch(addr, rd, t);
      check_word("ifu_rdata_o", rd, ref_word(addr));
    end
    report_test("fetch_halves", errs);
  endtask

  task automatic test_store_merge();
    int errs;
    errs = err_count;
    for (int i = 0; i < 8; i++)
      store_and_track(ADDR_W'(32'h400 + i), SZ_BYTE, $urandom);
    for (int i = 0; i < 4; i++)
      store_and_track(ADDR_W'(32'h408 + 2 * i), SZ_HALF, $urandom);
    store_and_track(32'h410, SZ_WORD, $urandom);
    store_and_track(32'h414, SZ_WORD, $urandom);
    for (int i = 0; i < 6; i++)
      load_and_compare(ADDR_W'(32'h400 + 4 * i), SZ_WORD);
    report_test("store_merge", errs);
  endtask

  task automatic test_priority();
    int                errs;
    logic [DATA_W-1:0] ifu_rd;
    logic [DATA_W-1:0] lsu_rd;
    time               ifu_t;
    time               lsu_t;
    errs = err_count;
    fork
      ifu_fetch(32'h1f0, ifu_rd, ifu_t);
      lsu_transfer(1'b0, 32'h1f8, SZ_WORD, '0, lsu_rd, lsu_t);
    join
    check_bit("lsu_ack_o before ifu_ack_o", lsu_t < ifu_t, 1'b1);
    check_word("ifu_rdata_o", ifu_rd, ref_word(32'h1f0));
    check_word("lsu_rdata_o", lsu_rd, ref_word(32'h1f8));
    report_test("priority", errs);
  endtask

  task automatic test_mixed_random();
    int                errs;
    xfer_size_e        size;
    logic [ADDR_W-1:0] mask;
    logic [ADDR_W-1:0] addr;
    errs = err_count;
    for (int i = 0; i < MIXED_OPS; i++)
    begin
      size = xfer_size_e'($urandom % 3);
      mask = ~((32'd1 << size) - 32'd1);  // natural alignment
      addr = 32'h800 | ($urandom & 32'hff & mask);
      if ($urandom % 2)
        store_and_track(addr, size, $urandom);
      else
        load_and_compare(addr, size);
    end
    report_test("mixed_random", errs);
  endtask

  task automatic test_mtime();
    int                errs;
    logic [DATA_W-1:0] lo_first;
    logic [DATA_W-1:0] lo_second;
    logic [DATA_W-1:0] hi;
    time               t;
    errs = err_count;
    ar_seen  <= 1'b0;
    watch_ar <= 1'b1;
    lsu_transfer(1'b0, CLINT_BASE + MTIME_LO_OFS, SZ_WORD, '0, lo_first, t);
    lsu_transfer(1'b0, CLINT_BASE + MTIME_LO_OFS, SZ_WORD, '0, lo_second, t);
    lsu_transfer(1'b0, CLINT_BASE + MTIME_HI_OFS, SZ_WORD, '0, hi, t);
    watch_ar <= 1'b0;
    check_bit("mtime_lo increasing", lo_second > lo_first, 1'b1);
    check_word("mtime_hi", hi, '0);
    check_bit("m_arvalid_o during timer loads", ar_seen, 1'b0);
    report_test("mtime", errs);
  endtask

  initial
  begin
    void'($urandom(SEED));
    err_count    = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    exp_size     = SZ_WORD;
    for (int i = 0; i < MEM_BYTES; i++)
      ref_mem[i] = fill_byte(ADDR_W'(i));
    rst       <= 1'b1;
    ifu_req   <= 1'b0;
    ifu_addr  <= '0;
    lsu_req   <= 1'b0;
    lsu_we    <= 1'b0;
    lsu_addr  <= '0;
    lsu_size  <= SZ_WORD;
    lsu_wdata <= '0;
    watch_ar  <= 1'b0;
    ar_seen   <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    test_reset_levels();
    test_fetch_halves();
    test_store_merge();
    test_priority();
    test_mixed_random();
    test_mtime();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* mem_bus_top.f */
hw/bus_pkg.sv
hw/arb_pkg.sv
hw/client_arbiter.sv
hw/axi_master_seq.sv
hw/clint_timer.sv
hw/resp_router.sv
hw/mem_bus_top.sv
dv/axi_mem_model.sv
dv/mem_bus_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_bus_tb \
  -f mem_bus_top.f -Mdir obj_dir

out=$(./obj_dir/Vmem_bus_tb 2>&1) || true
echo "$out"

if grep -qx "TEST OK" <<< "$out"; then
  exit 0
else
  exit 1
fi
